/* rtl/fetch_pkg.sv */
// Word-addressed 32-bit fetch; ROM must sit above all cached RAM, L1i is direct mapped
package fetch_pkg;

    // ========================================================================
    // Memory map
    // ========================================================================

    localparam int WORD_W = 32;

    // First ROM word, also the PC after reset
    localparam logic [WORD_W-1:0] ROM_ADDRESS = 32'h0780_0000;

    // ROM word address width at the fetch port
    localparam int ROM_ADDR_W = 10;

    // ========================================================================
    // L1i line geometry
    // ========================================================================

    // PC[2:0] selects the word, PC[9:3] the line, PC[25:10] is the tag
    localparam int L1I_OFFSET_W = 3;
    localparam int L1I_INDEX_W  = 7;
    localparam int L1I_TAG_W    = 16;
    localparam int L1I_WORDS    = 8;

    // Line layout: [273:18] data words, [17:2] tag, [1] valid
    localparam int L1I_VALID_BIT = 1;
    localparam int L1I_TAG_LSB   = 2;
    localparam int L1I_TAG_MSB   = 17;
    localparam int L1I_DATA_LSB  = 18;
    localparam int L1I_LINE_W    = 274;

    // Miss handler states
    localparam logic [1:0] MISS_IDLE         = 2'b00;
    localparam logic [1:0] MISS_STARTED      = 2'b01;
    localparam logic [1:0] MISS_WAIT_DONE    = 2'b10;
    localparam logic [1:0] MISS_RESULT_READY = 2'b11;

endpackage

/* rtl/pc_sequencer.sv */
// FE1 stage; PC addresses at or above ROM_ADDRESS go to ROM, only the low ROM_ADDR_W bits are used
`timescale 1ns/1ps

module pc_sequencer (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 redirect,
    input  logic [31:0]                          redirect_addr,
    input  logic                                 decode_stall,
    input  logic                                 fetch_miss,
    output logic [fetch_pkg::ROM_ADDR_W-1:0]     rom_addr,
    output logic                                 rom_oe,
    output logic                                 rom_hold,
    output logic [fetch_pkg::L1I_INDEX_W-1:0]    l1i_addr,
    output logic [31:0]                          pc_fe2,
    output logic                                 rom_fe2,
    output logic                                 cache_fetch_fe2
);

    logic [31:0] pc;
    logic [31:0] rom_offset;
    logic        rom_region;
    logic        fe1_stall;
    logic        valid_fe2;

    // FE1 stalls on back-pressure and while FE2 waits for a miss
    assign fe1_stall = decode_stall || fetch_miss;

    // ========================================================================
    // Program counter
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= fetch_pkg::ROM_ADDRESS;
        end else if (redirect) begin
            pc <= redirect_addr;
        end else if (!fe1_stall) begin
            pc <= pc + 32'd1;
        end
    end

    // Fetch address decode
    assign rom_region = pc >= fetch_pkg::ROM_ADDRESS;
    assign rom_offset = pc - fetch_pkg::ROM_ADDRESS;

    assign rom_addr = rom_offset[fetch_pkg::ROM_ADDR_W-1:0];
    assign rom_oe   = rom_region && !redirect;
    // ROM keeps its output for the word that sits in FE2
    assign rom_hold = fe1_stall;

    // Line index of the current PC
    assign l1i_addr = pc[fetch_pkg::L1I_OFFSET_W +: fetch_pkg::L1I_INDEX_W];

    // ========================================================================
    // FE1 to FE2 registers
    // ========================================================================

    // valid_fe2 tags a real fetch, a cleared stage is a bubble
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            pc_fe2    <= 32'd0;
            rom_fe2   <= 1'b0;
            valid_fe2 <= 1'b0;
        end else if (!fe1_stall) begin
            pc_fe2    <= pc;
            rom_fe2   <= rom_region;
            valid_fe2 <= 1'b1;
        end
    end

    assign cache_fetch_fe2 = valid_fe2 && !rom_fe2;

endmodule

/* rtl/l1i_hit_decode.sv */
// FE2 hit check; the line must arrive one cycle after its index, held copy is used while FE2 waits
`timescale 1ns/1ps

module l1i_hit_decode (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [31:0]                         pc_fe2,
    input  logic                                cache_fetch_fe2,
    input  logic [fetch_pkg::L1I_LINE_W-1:0]    l1i_line,
    input  logic                                decode_stall,
    input  logic                                redirect,
    output logic                                tag_match,
    output logic                                hit,
    output logic [31:0]                         hit_word
);

    logic [fetch_pkg::L1I_LINE_W-1:0]   line_held;
    logic [fetch_pkg::L1I_LINE_W-1:0]   line_used;
    logic                               stall_prev;
    logic [31:0]                        pc_prev;
    logic                               use_held;
    logic [fetch_pkg::L1I_TAG_W-1:0]    pc_tag;
    logic [fetch_pkg::L1I_OFFSET_W-1:0] pc_offset;
    logic [fetch_pkg::WORD_W-1:0]       line_words [fetch_pkg::L1I_WORDS];

    // FE2 held at the last edge, so the array now shows the line of the FE1 PC.
    // Back-pressure shows up as the stall, a pending miss as an unchanged PC
    assign use_held  = stall_prev || (pc_fe2 == pc_prev);
    assign line_used = use_held ? line_held : l1i_line;

    always_ff @(posedge clk) begin
        if (reset) begin
            line_held  <= '0;
            stall_prev <= 1'b0;
            pc_prev    <= 32'd0;
        end else begin
            line_held  <= line_used;
            stall_prev <= decode_stall && !redirect;
            pc_prev    <= pc_fe2;
        end
    end

    // Tag and offset of the FE2 PC
    assign pc_tag    = pc_fe2[fetch_pkg::L1I_OFFSET_W + fetch_pkg::L1I_INDEX_W +:
                              fetch_pkg::L1I_TAG_W];
    assign pc_offset = pc_fe2[fetch_pkg::L1I_OFFSET_W-1:0];

    assign tag_match = line_used[fetch_pkg::L1I_VALID_BIT] &&
                       (line_used[fetch_pkg::L1I_TAG_MSB:fetch_pkg::L1I_TAG_LSB] == pc_tag);
    assign hit       = cache_fetch_fe2 && tag_match;

    // Word select within the line
    for (genvar w = 0; w < fetch_pkg::L1I_WORDS; w++) begin : g_words
        assign line_words[w] =
            line_used[fetch_pkg::L1I_DATA_LSB + w * fetch_pkg::WORD_W +: fetch_pkg::WORD_W];
    end

    assign hit_word = line_words[pc_offset];

endmodule

/* rtl/l1i_miss_handler.sv */
// FE2 miss FSM; the controller must not raise done for a request after its flush pulse
`timescale 1ns/1ps

module l1i_miss_handler (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] pc_fe2,
    input  logic        cache_fetch_fe2,
    input  logic        tag_match,
    input  logic        decode_stall,
    input  logic        redirect,
    input  logic        l1i_ctrl_done,
    input  logic [31:0] l1i_ctrl_result,
    output logic        fetch_miss,
    output logic        result_ready,
    output logic [31:0] saved_result,
    output logic [31:0] l1i_ctrl_addr,
    output logic        l1i_ctrl_start,
    output logic        l1i_ctrl_flush
);

    logic [1:0] state;

    assign result_ready = state == fetch_pkg::MISS_RESULT_READY;

    // Miss stays asserted until the saved result can be handed on
    assign fetch_miss = !result_ready && cache_fetch_fe2 && !tag_match;

    // The missing PC sits in FE2 for the whole request
    assign l1i_ctrl_addr = pc_fe2;

    // ========================================================================
    // Miss state machine
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= fetch_pkg::MISS_IDLE;
            l1i_ctrl_start <= 1'b0;
            l1i_ctrl_flush <= 1'b0;
        end else begin
            case (state)
                fetch_pkg::MISS_IDLE: begin
                    l1i_ctrl_start <= 1'b0;
                    l1i_ctrl_flush <= 1'b0;
                    // No request for a fetch that is being thrown away
                    if (fetch_miss && !redirect) begin
                        l1i_ctrl_start <= 1'b1;
                        state          <= fetch_pkg::MISS_STARTED;
                    end
                end

                fetch_pkg::MISS_STARTED: begin
                    l1i_ctrl_start <= 1'b0;
                    // Abort on redirect, or when the line turned up after all
                    if (redirect || tag_match) begin
                        l1i_ctrl_flush <= 1'b1;
                        state          <= fetch_pkg::MISS_IDLE;
                    end else begin
                        state <= fetch_pkg::MISS_WAIT_DONE;
                    end
                end

                fetch_pkg::MISS_WAIT_DONE: begin
                    if (redirect || tag_match) begin
                        l1i_ctrl_flush <= 1'b1;
                        state          <= fetch_pkg::MISS_IDLE;
                    end else if (l1i_ctrl_done) begin
                        state <= fetch_pkg::MISS_RESULT_READY;
                    end
                end

                fetch_pkg::MISS_RESULT_READY: begin
                    // Wait out the stall, otherwise the same PC would miss again
                    if (!decode_stall || redirect) begin
                        state <= fetch_pkg::MISS_IDLE;
                    end
                end

                default: begin
                    state <= fetch_pkg::MISS_IDLE;
                end
            endcase
        end
    end

    // Controller result, only meaningful in the result-ready state
    always_ff @(posedge clk) begin
        if (state == fetch_pkg::MISS_WAIT_DONE && l1i_ctrl_done) begin
            saved_result <= l1i_ctrl_result;
        end
    end

endmodule

/* rtl/fetch_frontend.sv */
// Fetch front end FE1/FE2; redirect is a one-cycle pulse, instr of zero is a bubble
`timescale 1ns/1ps

module fetch_frontend (
    input  logic                                clk,
    input  logic                                reset,

    // ROM fetch port
    output logic [fetch_pkg::ROM_ADDR_W-1:0]    rom_addr,
    output logic                                rom_oe,
    output logic                                rom_hold,
    input  logic [31:0]                         rom_q,

    // L1i array port
    output logic [fetch_pkg::L1I_INDEX_W-1:0]   l1i_addr,
    input  logic [fetch_pkg::L1I_LINE_W-1:0]    l1i_line,

    // Cache controller
    output logic [31:0]                         l1i_ctrl_addr,
    output logic                                l1i_ctrl_start,
    output logic                                l1i_ctrl_flush,
    input  logic                                l1i_ctrl_done,
    input  logic [31:0]                         l1i_ctrl_result,

    // Later stages
    input  logic                                redirect,
    input  logic [31:0]                         redirect_addr,
    input  logic                                decode_stall,
    output logic [31:0]                         instr,
    output logic [31:0]                         instr_pc
);

    logic [31:0] pc_fe2;
    logic        rom_fe2;
    logic        cache_fetch_fe2;
    logic        tag_match;
    logic        hit;
    logic [31:0] hit_word;
    logic        fetch_miss;
    logic        result_ready;
    logic [31:0] saved_result;
    logic [31:0] result_fe2;

    pc_sequencer i_pc_sequencer (
        .clk             (clk),
        .reset           (reset),
        .redirect        (redirect),
        .redirect_addr   (redirect_addr),
        .decode_stall    (decode_stall),
        .fetch_miss      (fetch_miss),
        .rom_addr        (rom_addr),
        .rom_oe          (rom_oe),
        .rom_hold        (rom_hold),
        .l1i_addr        (l1i_addr),
        .pc_fe2          (pc_fe2),
        .rom_fe2         (rom_fe2),
        .cache_fetch_fe2 (cache_fetch_fe2)
    );

    l1i_hit_decode i_l1i_hit_decode (
        .clk             (clk),
        .reset           (reset),
        .pc_fe2          (pc_fe2),
        .cache_fetch_fe2 (cache_fetch_fe2),
        .l1i_line        (l1i_line),
        .decode_stall    (decode_stall),
        .redirect        (redirect),
        .tag_match       (tag_match),
        .hit             (hit),
        .hit_word        (hit_word)
    );

    l1i_miss_handler i_l1i_miss_handler (
        .clk             (clk),
        .reset           (reset),
        .pc_fe2          (pc_fe2),
        .cache_fetch_fe2 (cache_fetch_fe2),
        .tag_match       (tag_match),
        .decode_stall    (decode_stall),
        .redirect        (redirect),
        .l1i_ctrl_done   (l1i_ctrl_done),
        .l1i_ctrl_result (l1i_ctrl_result),
        .fetch_miss      (fetch_miss),
        .result_ready    (result_ready),
        .saved_result    (saved_result),
        .l1i_ctrl_addr   (l1i_ctrl_addr),
        .l1i_ctrl_start  (l1i_ctrl_start),
        .l1i_ctrl_flush  (l1i_ctrl_flush)
    );

    // FE2 result, bubbles while a miss is still pending
    assign result_fe2 = rom_fe2      ? rom_q :
                        result_ready ? saved_result :
                        fetch_miss   ? 32'd0 :
                        hit          ? hit_word :
                        32'd0;

    // FE2 to REG registers
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            instr    <= 32'd0;
            instr_pc <= 32'd0;
        end else if (!decode_stall) begin
            instr    <= result_fe2;
            instr_pc <= pc_fe2;
        end
    end

endmodule

/* tb/fetch_memory_model.sv */
// Behavioral ROM, L1i array and cache controller; word content depends only on its address, controller never fills lines
`timescale 1ns/1ps

module fetch_memory_model (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [fetch_pkg::ROM_ADDR_W-1:0]    rom_addr,
    input  logic                                rom_oe,
    input  logic                                rom_hold,
    output logic [31:0]                         rom_q,
    input  logic [fetch_pkg::L1I_INDEX_W-1:0]   l1i_addr,
    output logic [fetch_pkg::L1I_LINE_W-1:0]    l1i_line,
    input  logic [31:0]                         l1i_ctrl_addr,
    input  logic                                l1i_ctrl_start,
    input  logic                                l1i_ctrl_flush,
    output logic                                l1i_ctrl_done,
    output logic [31:0]                         l1i_ctrl_result
);

    logic                               present [128];
    logic [fetch_pkg::L1I_TAG_W-1:0]    line_tag [128];
    logic [fetch_pkg::L1I_LINE_W-1:0]   line_next;
    logic                               busy;
    logic [3:0]                         count;
    logic [31:0]                        req_addr;
    integer                             seed = 32'h222d_a434;
    integer                             w;

    function automatic logic [31:0] stored_word(input logic [31:0] a);
        return (a ^ 32'h5a5a_0000) | 32'd1;
    endfunction

    task automatic clear_lines();
        for (int i = 0; i < 128; i++) begin
            present[i]  = 1'b0;
            line_tag[i] = '0;
        end
    endtask

    // Loads every line touched by the words from base on
    task automatic fill_region(input logic [31:0] base, input int words);
        logic [31:0] a;
        a = base & ~32'd7;
        while (a < base + words) begin
            present[a[9:3]]  = 1'b1;
            line_tag[a[9:3]] = a[25:10];
            a = a + 32'd8;
        end
    endtask

    // ROM output freezes in the cycle after a hold
    always @(posedge clk) begin
        if (reset) begin
            rom_q <= 32'd0;
        end else if (!rom_hold) begin
            rom_q <= rom_oe ? stored_word(fetch_pkg::ROM_ADDRESS + rom_addr) : 32'd0;
        end
    end

    // L1i array, one cycle read latency
    always @(posedge clk) begin
        line_next = '0;
        if (present[l1i_addr]) begin
            line_next[fetch_pkg::L1I_VALID_BIT] = 1'b1;
            line_next[fetch_pkg::L1I_TAG_MSB:fetch_pkg::L1I_TAG_LSB] = line_tag[l1i_addr];
            for (w = 0; w < fetch_pkg::L1I_WORDS; w++) begin
                line_next[fetch_pkg::L1I_DATA_LSB + w * 32 +: 32] =
                    stored_word({6'd0, line_tag[l1i_addr], l1i_addr, w[2:0]});
            end
        end
        l1i_line <= line_next;
    end

    // ========================================================================
    // Cache controller, done comes 2 to 9 edges after start
    // ========================================================================

    always @(posedge clk) begin
        l1i_ctrl_done <= 1'b0;
        if (reset || l1i_ctrl_flush) begin
            busy <= 1'b0;
        end else if (l1i_ctrl_start) begin
            busy     <= 1'b1;
            count    <= 4'd2 + 4'($random(seed) & 7);
            req_addr <= l1i_ctrl_addr;
        end else if (busy) begin
            if (count == 4'd1) begin
                l1i_ctrl_done   <= 1'b1;
                l1i_ctrl_result <= stored_word(req_addr);
                busy            <= 1'b0;
            end else begin
                count <= count - 4'd1;
            end
        end
    end

endmodule

/* tb/tb_fetch_frontend.sv */
// Directed fetch tests; RAM targets stay below 2**26, ROM targets within 1024 words of ROM start
`timescale 1ns/1ps

module tb_fetch_frontend;

    logic                               clk;
    logic                               reset;
    logic [fetch_pkg::ROM_ADDR_W-1:0]   rom_addr;
    logic                               rom_oe;
    logic                               rom_hold;
    logic [31:0]                        rom_q;
    logic [fetch_pkg::L1I_INDEX_W-1:0]  l1i_addr;
    logic [fetch_pkg::L1I_LINE_W-1:0]   l1i_line;
    logic [31:0]                        l1i_ctrl_addr;
    logic                               l1i_ctrl_start;
    logic                               l1i_ctrl_flush;
    logic                               l1i_ctrl_done;
    logic [31:0]                        l1i_ctrl_result;
    logic                               redirect;
    logic [31:0]                        redirect_addr;
    logic                               decode_stall;
    logic [31:0]                        instr;
    logic [31:0]                        instr_pc;

    integer      errors = 0;
    integer      accepted = 0;
    integer      start_count = 0;
    integer      flush_count = 0;
    integer      seed = 32'h222d_a434;
    logic [31:0] next_pc = fetch_pkg::ROM_ADDRESS;
    logic [31:0] last_pc = 32'd0;
    logic [31:0] expect_start_addr = 32'd0;
    logic        track_starts = 1'b0;
    logic        prev_stall = 1'b0;
    logic        prev_redirect = 1'b0;
    logic        prev_start = 1'b0;
    logic        prev_flush = 1'b0;
    logic [31:0] prev_instr = 32'd0;
    logic [31:0] prev_instr_pc = 32'd0;

    fetch_frontend i_dut (.*);

    fetch_memory_model i_memory (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        return (a ^ 32'h5a5a_0000) | 32'd1;
    endfunction

    task automatic value_error(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        errors++;
    endtask

    // ========================================================================
    // Stream monitor, sampled mid-cycle
    // ========================================================================

    always @(negedge clk) begin
        if (!reset) begin
            if (prev_stall && !prev_redirect &&
                (instr !== prev_instr || instr_pc !== prev_instr_pc)) begin
                value_error($sformatf("instr %h pc %h changed under stall", instr, instr_pc));
            end
            // Word in REG during a redirect is wrong-path and dropped
            if (redirect) begin
                next_pc = redirect_addr;
            end else if (!decode_stall && instr != 32'd0) begin
                if (instr !== expected_word(instr_pc)) begin
                    value_error($sformatf("instr %h at pc %h, expected %h",
                                          instr, instr_pc, expected_word(instr_pc)));
                end
                if (instr_pc !== next_pc) begin
                    value_error($sformatf("instr_pc %h, expected %h", instr_pc, next_pc));
                end
                next_pc  = instr_pc + 32'd1;
                last_pc  = instr_pc;
                accepted = accepted + 1;
            end
            if (l1i_ctrl_start) begin
                if (prev_start) begin
                    value_error("l1i_ctrl_start high for more than one cycle");
                end
                start_count = start_count + 1;
                if (track_starts && l1i_ctrl_addr !== expect_start_addr) begin
                    value_error($sformatf("l1i_ctrl_addr %h, expected %h",
                                          l1i_ctrl_addr, expect_start_addr));
                end
                expect_start_addr = l1i_ctrl_addr + 32'd1;
            end
            if (l1i_ctrl_flush) begin
                if (prev_flush) begin
                    value_error("l1i_ctrl_flush high for more than one cycle");
                end
                flush_count = flush_count + 1;
            end
        end
        prev_stall    = decode_stall;
        prev_redirect = redirect;
        prev_start    = l1i_ctrl_start;
        prev_flush    = l1i_ctrl_flush;
        prev_instr    = instr;
        prev_instr_pc = instr_pc;
    end

    task automatic wait_accepted(input int n, input string what);
        int target;
        int cycles;
        target = accepted + n;
        cycles = 0;
        while (accepted < target && cycles < 1000) begin
            @(posedge clk);
            cycles++;
        end
        if (accepted < target) begin
            $display("Timed out at %0t waiting for %s", $time, what);
            errors++;
        end
    endtask

    task automatic redirect_to(input logic [31:0] target);
        @(posedge clk);
        redirect      <= 1'b1;
        redirect_addr <= target;
        @(posedge clk);
        redirect      <= 1'b0;
    endtask

    // Toggles decode_stall in random spans until n more words are accepted
    task automatic stall_stream(input int n);
        int target;
        int cycles;
        int span;
        target = accepted + n;
        cycles = 0;
        span   = 0;
        while (accepted < target && cycles < 1000) begin
            @(posedge clk);
            cycles++;
            if (span == 0) begin
                decode_stall <= !decode_stall;
                span = 1 + ($random(seed) & 3);
            end
            span--;
        end
        @(posedge clk);
        decode_stall <= 1'b0;
        if (accepted < target) begin
            $display("Timed out at %0t waiting for a stalled stream", $time);
            errors++;
        end
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================

    task automatic check_reset_and_rom();
        @(negedge clk);
        if (instr !== 32'd0 || instr_pc !== 32'd0) begin
            value_error("instr or instr_pc not zero after reset");
        end
        if (l1i_ctrl_start !== 1'b0 || l1i_ctrl_flush !== 1'b0 || rom_oe !== 1'b1) begin
            value_error("controller strobes or rom_oe wrong after reset");
        end
        wait_accepted(21, "ROM stream");
        if (last_pc !== fetch_pkg::ROM_ADDRESS + 32'd20) begin
            value_error($sformatf("ROM stream ended at %h", last_pc));
        end
    endtask

    task automatic run_cache_hits();
        int starts;
        // One pass over all 128 indexes, each line tagged once
        i_memory.fill_region(32'h0001_2340, 1024);
        starts = start_count;
        redirect_to(32'h0001_2345);
        wait_accepted(24, "cache hit stream");
        if (start_count != starts) begin
            value_error("l1i_ctrl_start raised during a hit stream");
        end
        if (last_pc !== 32'h0001_2345 + 32'd23) begin
            value_error($sformatf("hit stream ended at %h", last_pc));
        end
    endtask

    task automatic run_cache_misses();
        int starts;
        starts            = start_count;
        expect_start_addr = 32'h0002_4013;
        track_starts      = 1'b1;
        redirect_to(32'h0002_4013);
        // Old stream is flushed by now, so only the new target misses
        i_memory.clear_lines();
        wait_accepted(12, "miss stream");
        track_starts = 1'b0;
        if (start_count - starts != 12) begin
            value_error($sformatf("%0d starts for 12 misses", start_count - starts));
        end
        if (last_pc !== 32'h0002_4013 + 32'd11) begin
            value_error($sformatf("miss stream ended at %h", last_pc));
        end
    endtask

    task automatic run_back_pressure();
        redirect_to(fetch_pkg::ROM_ADDRESS + 32'd100);
        stall_stream(30);
        i_memory.fill_region(32'h0003_0106, 256);
        redirect_to(32'h0003_0106);
        stall_stream(30);
    endtask

    task automatic abort_miss_on_redirect();
        int flushes;
        int cycles;
        flushes = flush_count;
        redirect_to(32'h0004_0000);
        i_memory.clear_lines();
        cycles = 0;
        while (!l1i_ctrl_start && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (!l1i_ctrl_start) begin
            $display("Timed out at %0t waiting for l1i_ctrl_start", $time);
            errors++;
        end
        redirect_to(fetch_pkg::ROM_ADDRESS + 32'd300);
        wait_accepted(4, "stream after aborted miss");
        if (flush_count - flushes != 1) begin
            value_error($sformatf("%0d flush pulses, expected 1", flush_count - flushes));
        end
        if (last_pc !== fetch_pkg::ROM_ADDRESS + 32'd303) begin
            value_error($sformatf("stream after abort ended at %h", last_pc));
        end
    endtask

    initial begin
        reset         = 1'b1;
        redirect      = 1'b0;
        redirect_addr = 32'd0;
        decode_stall  = 1'b0;
        i_memory.clear_lines();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        check_reset_and_rom();
        run_cache_hits();
        run_cache_misses();
        run_back_pressure();
        abort_miss_on_redirect();
        $display("Finished with %0d errors, %0d instructions accepted", errors, accepted);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* all.f */
rtl/fetch_pkg.sv
rtl/pc_sequencer.sv
rtl/l1i_hit_decode.sv
rtl/l1i_miss_handler.sv
rtl/fetch_frontend.sv
tb/fetch_memory_model.sv
tb/tb_fetch_frontend.sv
